//--- design/load_pkg.sv
// ----------------------------------------
// shared widths and types of the load unit
// load operation codes
// issue queue request, data cache request and response structs
// load buffer entry
// ----------------------------------------

package load_pkg;

  // ----------------------------------------
  // widths
  localparam int unsigned xlen    = 64;
  localparam int unsigned addr_w  = 32;
  localparam int unsigned index_w = 12;
  localparam int unsigned tag_w   = addr_w - index_w;

  typedef logic [xlen-1:0]    xlen_t;
  typedef logic [addr_w-1:0]  addr_t;
  // index doubles as the page offset seen by the store unit
  typedef logic [index_w-1:0] dcache_index_t;
  typedef logic [tag_w-1:0]   dcache_tag_t;
  typedef logic [2:0]         trans_id_t;
  // cache request id is the load buffer slot, wide enough for 16 slots
  typedef logic [3:0]         req_id_t;
  typedef logic [2:0]         byte_offset_t;
  typedef logic [7:0]         be_t;
  typedef logic [1:0]         size_t;

  // ----------------------------------------
  // load operations
  typedef logic [2:0] load_op_t;

  localparam load_op_t OP_LD  = 3'd0;
  localparam load_op_t OP_LW  = 3'd1;
  localparam load_op_t OP_LWU = 3'd2;
  localparam load_op_t OP_LH  = 3'd3;
  localparam load_op_t OP_LHU = 3'd4;
  localparam load_op_t OP_LB  = 3'd5;
  localparam load_op_t OP_LBU = 3'd6;

  // one load from the issue queue
  typedef struct packed {
    trans_id_t trans_id;
    addr_t     vaddr;
    load_op_t  op;
    be_t       be;
  } load_req_t;

  // request side of the data cache port
  typedef struct packed {
    logic          data_req;
    dcache_index_t address_index;
    dcache_tag_t   address_tag;
    logic          tag_valid;
    logic          kill_req;
    be_t           data_be;
    size_t         data_size;
    req_id_t       data_id;
  } dcache_req_t;

  // response side of the data cache port
  typedef struct packed {
    logic    data_gnt;
    logic    data_rvalid;
    req_id_t data_rid;
    xlen_t   data_rdata;
  } dcache_rsp_t;

  // what a load buffer slot remembers about an outstanding load
  typedef struct packed {
    trans_id_t    trans_id;
    byte_offset_t offset;
    load_op_t     op;
  } ldbuf_entry_t;

endpackage

//--- design/load_request_ctrl.sv
// ----------------------------------------
// load request FSM
// index phase with req/gnt, tag phase one cycle after the grant
// stalls on a page offset match or a full load buffer
// kills the tag cycle after a flush
// ----------------------------------------

`timescale 1ns/100ps

module load_request_ctrl #(
  parameter int unsigned ldbuf_depth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  load_pkg::load_req_t   load_i,
  input  logic                  page_offset_matches_i,
  input  logic                  dcache_gnt_i,
  input  logic                  ldbuf_full_i,
  input  load_pkg::req_id_t     ldbuf_free_id_i,
  output logic                  pop_ld_o,
  output load_pkg::dcache_req_t dcache_req_o,
  output logic                  ldbuf_w_o
);

  // keeps the request id inside the populated slots
  localparam load_pkg::req_id_t id_mask = load_pkg::req_id_t'(ldbuf_depth - 1);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } state_e;

  state_e state_d, state_q;

  logic                  data_req;
  logic                  tag_valid;
  logic                  kill_req;
  logic                  accept_req;
  logic                  grant;
  load_pkg::size_t       data_size;
  load_pkg::dcache_tag_t tag_q;

  // a new load is taken only with room left in the buffer
  assign accept_req = valid_i && !ldbuf_full_i;

  // ----------------------------------------
  // FSM next state and strobes
  always_comb begin
    state_d   = state_q;
    data_req  = 1'b0;
    tag_valid = 1'b0;
    kill_req  = 1'b0;

    case (state_q)
      // store with the same offset still pending
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end
      // hold the index until the cache grants
      WAIT_GNT: begin
        data_req = 1'b1;
        if (dcache_gnt_i) begin
          state_d = SEND_TAG;
        end
      end
      SEND_TAG: begin
        tag_valid = 1'b1;
        state_d   = IDLE;
      end
      // drop whatever the cache holds for the last index
      WAIT_FLUSH: begin
        tag_valid = 1'b1;
        kill_req  = 1'b1;
        state_d   = IDLE;
      end
      // idle is handled by the accept path below
      default: ;
    endcase

    // idle and tag cycle both take a new load, so loads run back to back
    if ((state_q == IDLE || state_q == SEND_TAG) && accept_req) begin
      if (!page_offset_matches_i) begin
        data_req = 1'b1;
        state_d  = dcache_gnt_i ? SEND_TAG : WAIT_GNT;
      end else begin
        state_d = WAIT_PAGE_OFFSET;
      end
    end

    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  // grant cycle writes the buffer and pops the issue queue
  assign grant     = data_req && dcache_gnt_i;
  assign pop_ld_o  = grant;
  assign ldbuf_w_o = grant;

  // transfer size from the operation
  always_comb begin
    case (load_i.op)
      load_pkg::OP_LD:                  data_size = 2'b11;
      load_pkg::OP_LW, load_pkg::OP_LWU: data_size = 2'b10;
      load_pkg::OP_LH, load_pkg::OP_LHU: data_size = 2'b01;
      default:                           data_size = 2'b00;
    endcase
  end

  assign dcache_req_o = '{
    data_req:      data_req,
    address_index: load_i.vaddr[load_pkg::index_w-1:0],
    address_tag:   tag_q,
    tag_valid:     tag_valid,
    kill_req:      kill_req,
    data_be:       load_i.be,
    data_size:     data_size,
    data_id:       ldbuf_free_id_i & id_mask
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag goes out in the cycle after the grant
  always_ff @(posedge clk_i) begin
    if (grant) begin
      tag_q <= load_i.vaddr[load_pkg::addr_w-1:load_pkg::index_w];
    end
  end

endmodule

//--- design/load_buffer.sv
// ----------------------------------------
// table of outstanding loads
// lowest free slot search and full flag
// flushed flags and retire decision on rvalid
// ----------------------------------------

`timescale 1ns/100ps

module load_buffer #(
  parameter int unsigned ldbuf_depth = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   ldbuf_w_i,
  input  load_pkg::ldbuf_entry_t wdata_i,
  input  logic                   kill_i,
  input  logic                   rvalid_i,
  input  load_pkg::req_id_t      rid_i,
  output logic                   ldbuf_full_o,
  output load_pkg::req_id_t      free_id_o,
  output logic                   valid_o,
  output load_pkg::trans_id_t    trans_id_o,
  output load_pkg::ldbuf_entry_t entry_o
);

  localparam int unsigned id_w = $clog2(ldbuf_depth);

  load_pkg::ldbuf_entry_t mem_q [ldbuf_depth];

  logic [ldbuf_depth-1:0] valid_d, valid_q;
  logic [ldbuf_depth-1:0] flushed_d, flushed_q;
  logic [id_w-1:0]        windex;
  logic [id_w-1:0]        rindex;
  logic [id_w-1:0]        last_id_q;

  // ----------------------------------------
  // free slot search
  // scan downwards so the lowest free slot wins
  always_comb begin
    windex = '0;
    for (int i = ldbuf_depth - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        windex = id_w'(i);
      end
    end
  end

  assign ldbuf_full_o = &valid_q;
  assign free_id_o    = load_pkg::req_id_t'(windex);
  assign rindex       = rid_i[id_w-1:0];

  // ----------------------------------------
  // slot bookkeeping
  always_comb begin
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight belongs to the flushed path
    if (flush_i) begin
      flushed_d = '1;
    end
    if (rvalid_i) begin
      valid_d[rindex] = 1'b0;
    end
    // a load granted this cycle is new and therefore clean
    if (ldbuf_w_i) begin
      valid_d[windex]   = 1'b1;
      flushed_d[windex] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      if (ldbuf_w_i) begin
        last_id_q <= windex;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ldbuf_w_i) begin
      mem_q[windex] <= wdata_i;
    end
  end

  // ----------------------------------------
  // retire
  // a kill only ever hits the slot written last
  assign valid_o    = rvalid_i && !flushed_q[rindex] && !(kill_i && (last_id_q == rindex));
  assign entry_o    = mem_q[rindex];
  assign trans_id_o = entry_o.trans_id;

endmodule

//--- design/load_result_align.sv
// ----------------------------------------
// load result realignment
// right shift by the byte offset
// sign or zero extension per load operation
// ----------------------------------------

`timescale 1ns/100ps

module load_result_align (
  input  load_pkg::xlen_t        rdata_i,
  input  load_pkg::ldbuf_entry_t entry_i,
  output load_pkg::xlen_t        result_o
);

  load_pkg::xlen_t        shifted;
  logic [7:0]             sign_bits;
  load_pkg::byte_offset_t sign_offset;
  logic                   is_signed;
  logic                   sign_bit;

  // move the accessed field down to bit 0
  assign shifted = rdata_i >> {entry_i.offset, 3'b000};

  // msb of every byte of the raw word
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      sign_bits[i] = rdata_i[8*i+7];
    end
  end

  assign is_signed = entry_i.op inside {load_pkg::OP_LW, load_pkg::OP_LH, load_pkg::OP_LB};

  // top byte of the accessed field
  always_comb begin
    case (entry_i.op)
      load_pkg::OP_LW: sign_offset = entry_i.offset + 3'd3;
      load_pkg::OP_LH: sign_offset = entry_i.offset + 3'd1;
      default:         sign_offset = entry_i.offset;
    endcase
  end

  // picked from the raw word in parallel with the shifter
  // zero for unsigned loads
  assign sign_bit = is_signed && sign_bits[sign_offset];

  // ----------------------------------------
  // result mux
  always_comb begin
    case (entry_i.op)
      load_pkg::OP_LW, load_pkg::OP_LWU: begin
        result_o = {{32{sign_bit}}, shifted[31:0]};
      end
      load_pkg::OP_LH, load_pkg::OP_LHU: begin
        result_o = {{48{sign_bit}}, shifted[15:0]};
      end
      load_pkg::OP_LB, load_pkg::OP_LBU: begin
        result_o = {{56{sign_bit}}, shifted[7:0]};
      end
      // full doubleword passes unchanged
      load_pkg::OP_LD: begin
        result_o = shifted;
      end
      default: begin
        result_o = shifted;
      end
    endcase
  end

endmodule

//--- design/load_unit.sv
// ----------------------------------------
// load unit top level
// request FSM, load buffer, result alignment
// ----------------------------------------

`timescale 1ns/100ps

module load_unit #(
  parameter int unsigned ldbuf_depth = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  logic                    valid_i,
  input  load_pkg::load_req_t     load_i,
  output logic                    pop_ld_o,
  input  logic                    page_offset_matches_i,
  output load_pkg::dcache_index_t page_offset_o,
  output load_pkg::dcache_req_t   dcache_req_o,
  input  load_pkg::dcache_rsp_t   dcache_rsp_i,
  output logic                    valid_o,
  output load_pkg::trans_id_t     trans_id_o,
  output load_pkg::xlen_t         result_o
);

  logic                   ldbuf_w;
  logic                   ldbuf_full;
  load_pkg::req_id_t      ldbuf_free_id;
  load_pkg::ldbuf_entry_t ldbuf_wdata;
  load_pkg::ldbuf_entry_t ldbuf_rdata;

  // store unit compares against the low address bits
  assign page_offset_o = load_i.vaddr[load_pkg::index_w-1:0];

  // what the response side needs to finish the load
  assign ldbuf_wdata = '{
    trans_id: load_i.trans_id,
    offset:   load_i.vaddr[2:0],
    op:       load_i.op
  };

  load_request_ctrl #(
    .ldbuf_depth (ldbuf_depth)
  ) u_request_ctrl (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .load_i                (load_i),
    .page_offset_matches_i (page_offset_matches_i),
    .dcache_gnt_i          (dcache_rsp_i.data_gnt),
    .ldbuf_full_i          (ldbuf_full),
    .ldbuf_free_id_i       (ldbuf_free_id),
    .pop_ld_o              (pop_ld_o),
    .dcache_req_o          (dcache_req_o),
    .ldbuf_w_o             (ldbuf_w)
  );

  load_buffer #(
    .ldbuf_depth (ldbuf_depth)
  ) u_load_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .ldbuf_w_i    (ldbuf_w),
    .wdata_i      (ldbuf_wdata),
    .kill_i       (dcache_req_o.kill_req),
    .rvalid_i     (dcache_rsp_i.data_rvalid),
    .rid_i        (dcache_rsp_i.data_rid),
    .ldbuf_full_o (ldbuf_full),
    .free_id_o    (ldbuf_free_id),
    .valid_o      (valid_o),
    .trans_id_o   (trans_id_o),
    .entry_o      (ldbuf_rdata)
  );

  load_result_align u_result_align (
    .rdata_i  (dcache_rsp_i.data_rdata),
    .entry_i  (ldbuf_rdata),
    .result_o (result_o)
  );

endmodule

//--- testbench/dcache_model.sv
// ----------------------------------------
// data cache responder for the load unit
// grants at random, answers granted requests in random order
// answers a killed request in its kill cycle
// ----------------------------------------

`timescale 1ns/100ps

module dcache_model #(
  parameter int unsigned ldbuf_depth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  flush_i,
  input  load_pkg::dcache_req_t req_i,
  output load_pkg::dcache_rsp_t rsp_o
);

  // one bit per request id still waiting for data
  logic [15:0]       pending_q;
  logic              gnt_q;
  logic              rvalid_q;
  load_pkg::req_id_t rid_q;
  load_pkg::xlen_t   rdata_q;

  assign rsp_o = '{
    data_gnt:    gnt_q,
    data_rvalid: rvalid_q,
    data_rid:    rid_q,
    data_rdata:  rdata_q
  };

  always @(posedge clk_i or negedge rst_ni) begin : respond
    logic [15:0]       pending;
    logic              found;
    int unsigned       start;
    load_pkg::req_id_t slot;
    if (!rst_ni) begin
      pending_q <= '0;
      gnt_q     <= 1'b0;
      rvalid_q  <= 1'b0;
      rid_q     <= '0;
      rdata_q   <= '0;
    end else begin
      pending = pending_q;
      found   = 1'b0;
      gnt_q   <= ($urandom_range(0, 1) == 0);
      rdata_q <= {$urandom, $urandom};
      if (req_i.data_req && gnt_q) begin
        if (flush_i) begin
          // tag phase gets killed next cycle, so the slot is answered right then
          found = 1'b1;
          rid_q <= req_i.data_id;
        end else begin
          pending[req_i.data_id] = 1'b1;
        end
      end
      // otherwise a random waiting id, now and then
      if (!found && $urandom_range(0, 3) == 0) begin
        start = $urandom_range(0, ldbuf_depth - 1);
        for (int i = 0; i < ldbuf_depth; i++) begin
          slot = load_pkg::req_id_t'((start + i) % ldbuf_depth);
          if (!found && pending[slot]) begin
            found         = 1'b1;
            pending[slot] = 1'b0;
            rid_q <= slot;
          end
        end
      end
      rvalid_q  <= found;
      pending_q <= pending;
    end
  end

endmodule

//--- testbench/tb_load_unit.sv
// ----------------------------------------
// testbench of the load unit
// clock, reset, random loads with flush and page offset stalls
// per slot reference model, concurrent checks
// watchdog and closing report
// ----------------------------------------

`timescale 1ns/100ps

module tb_load_unit;

  localparam int unsigned ldbuf_depth = 4;
  localparam int unsigned n_loads     = 200;
  // 40 cycles of 10 ns per load
  localparam int unsigned watchdog_ns = n_loads * 40 * 10;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    valid_i;
  load_pkg::load_req_t     load_i;
  logic                    flush_i = 1'b0;
  logic                    page_offset_matches_i = 1'b0;
  logic                    pop_ld_o;
  load_pkg::dcache_index_t page_offset;
  load_pkg::dcache_req_t   dcache_req;
  load_pkg::dcache_rsp_t   dcache_rsp;
  logic                    valid_o;
  load_pkg::trans_id_t     trans_id_o;
  load_pkg::xlen_t         result_o;

  // reference model, indexed by request id
  logic [15:0]           busy_q;
  logic [15:0]           flushed_q;
  load_pkg::trans_id_t   tid_q [16];
  load_pkg::addr_t       addr_q [16];
  load_pkg::load_op_t    op_q [16];
  load_pkg::dcache_tag_t tag_q;
  logic                  wait_gnt_q;
  int unsigned           outstanding;
  load_pkg::xlen_t       exp_result;
  logic                  grant;
  logic                  dut_quiet;
  logic                  side_on;
  int unsigned           match_left = 0;
  int unsigned           pops;
  int unsigned           retired;
  int unsigned           flushed_rsp;
  int unsigned           errors = 0;

  load_unit #(
    .ldbuf_depth (ldbuf_depth)
  ) u_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .valid_i               (valid_i),
    .load_i                (load_i),
    .pop_ld_o              (pop_ld_o),
    .page_offset_matches_i (page_offset_matches_i),
    .page_offset_o         (page_offset),
    .dcache_req_o          (dcache_req),
    .dcache_rsp_i          (dcache_rsp),
    .valid_o               (valid_o),
    .trans_id_o            (trans_id_o),
    .result_o              (result_o)
  );

  dcache_model #(
    .ldbuf_depth (ldbuf_depth)
  ) u_dcache (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .req_i   (dcache_req),
    .rsp_o   (dcache_rsp)
  );

  always #5 clk_i = ~clk_i;

  task automatic flag_error(input string msg);
    errors++;
    $display("FAIL %0t: %s", $time, msg);
  endtask

  // log2 of the access size in bytes
  function automatic int unsigned size_of_op(input load_pkg::load_op_t op);
    case (op)
      load_pkg::OP_LD:                   return 3;
      load_pkg::OP_LW, load_pkg::OP_LWU: return 2;
      load_pkg::OP_LH, load_pkg::OP_LHU: return 1;
      default:                           return 0;
    endcase
  endfunction

  // random load, naturally aligned to its size
  function automatic load_pkg::load_req_t make_load(input int unsigned n);
    load_pkg::load_req_t req;
    int unsigned         sz;
    req.trans_id = load_pkg::trans_id_t'(n);
    req.op       = load_pkg::load_op_t'($urandom_range(0, 6));
    req.vaddr    = $urandom;
    sz           = size_of_op(req.op);
    req.vaddr = req.vaddr & ~((32'd1 << sz) - 32'd1);
    req.be    = load_pkg::be_t'(((32'd1 << (32'd1 << sz)) - 32'd1) << req.vaddr[2:0]);
    return req;
  endfunction

  // field at the byte offset, widened by the rule of the operation
  function automatic load_pkg::xlen_t extend_load(input load_pkg::xlen_t word,
                                                  input logic [2:0] offset,
                                                  input load_pkg::load_op_t op);
    load_pkg::xlen_t field;
    field = word >> (8 * int'(offset));
    case (op)
      load_pkg::OP_LW:  return {{32{field[31]}}, field[31:0]};
      load_pkg::OP_LWU: return {32'd0, field[31:0]};
      load_pkg::OP_LH:  return {{48{field[15]}}, field[15:0]};
      load_pkg::OP_LHU: return {48'd0, field[15:0]};
      load_pkg::OP_LB:  return {{56{field[7]}}, field[7:0]};
      load_pkg::OP_LBU: return {56'd0, field[7:0]};
      default:          return field;
    endcase
  endfunction

  assign grant       = dcache_req.data_req && dcache_rsp.data_gnt;
  assign outstanding = $countones(busy_q);
  assign dut_quiet   = !(dcache_req.data_req || dcache_req.tag_valid || dcache_req.kill_req ||
                         pop_ld_o || valid_o);
  assign exp_result  = extend_load(dcache_rsp.data_rdata,
                                   addr_q[dcache_rsp.data_rid][2:0],
                                   op_q[dcache_rsp.data_rid]);

  // ----------------------------------------
  // reference model
  always @(posedge clk_i or negedge rst_ni) begin : reference_model
    if (!rst_ni) begin
      busy_q      <= '0;
      flushed_q   <= '0;
      wait_gnt_q  <= 1'b0;
      pops        <= 0;
      retired     <= 0;
      flushed_rsp <= 0;
    end else begin
      wait_gnt_q <= dcache_req.data_req && !dcache_rsp.data_gnt;
      // flush hits everything in flight, a load granted now included
      if (flush_i) begin
        flushed_q <= flushed_q | busy_q;
      end
      if (grant) begin
        busy_q[dcache_req.data_id]    <= 1'b1;
        flushed_q[dcache_req.data_id] <= flush_i;
        tid_q[dcache_req.data_id]     <= load_i.trans_id;
        addr_q[dcache_req.data_id]    <= load_i.vaddr;
        op_q[dcache_req.data_id]      <= load_i.op;
        tag_q <= load_i.vaddr[31:12];
        pops  <= pops + 1;
      end
      if (dcache_rsp.data_rvalid) begin
        busy_q[dcache_rsp.data_rid] <= 1'b0;
        if (flushed_q[dcache_rsp.data_rid]) begin
          flushed_rsp <= flushed_rsp + 1;
        end
      end
      if (valid_o) begin
        retired <= retired + 1;
      end
    end
  end

  // ----------------------------------------
  // checks
  assert property (@(posedge clk_i) !rst_ni |-> dut_quiet)
    else flag_error("output active during reset");
  assert property (@(posedge clk_i) !rst_ni |=> dut_quiet)
    else flag_error("output active right after reset");
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_ld_o == grant)
    else flag_error("pop_ld_o differs from the grant cycle");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   page_offset == load_i.vaddr[11:0])
    else flag_error("page_offset_o differs from the request address");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   dcache_req.data_req |->
                   dcache_req.address_index == load_i.vaddr[11:0] &&
                   dcache_req.data_be == load_i.be &&
                   dcache_req.data_size == load_pkg::size_t'(size_of_op(load_i.op)))
    else flag_error("wrong index, byte enables or size on the request");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   grant |=> dcache_req.tag_valid && dcache_req.address_tag == tag_q)
    else flag_error("missing or wrong tag after grant");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   dcache_req.tag_valid |-> $past(grant) || $past(flush_i))
    else flag_error("tag_valid without a grant or flush before it");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   page_offset_matches_i && $past(page_offset_matches_i) && !wait_gnt_q
                   |-> !dcache_req.data_req)
    else flag_error("data_req while the page offset matches");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   outstanding == ldbuf_depth && !wait_gnt_q |-> !dcache_req.data_req)
    else flag_error("data_req with a full load buffer");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   flush_i |=> dcache_req.kill_req && dcache_req.tag_valid)
    else flag_error("no kill with tag_valid after flush");
  assert property (@(posedge clk_i) disable iff (!rst_ni) dcache_req.kill_req |-> $past(flush_i))
    else flag_error("kill_req without a flush");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   grant |-> dcache_req.data_id < ldbuf_depth && !busy_q[dcache_req.data_id])
    else flag_error("grant to a slot that is still in flight");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   dcache_rsp.data_rvalid |-> valid_o == !flushed_q[dcache_rsp.data_rid])
    else flag_error("valid_o wrong for the flush state of the slot");
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_o |-> dcache_rsp.data_rvalid)
    else flag_error("valid_o without rvalid");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   valid_o |-> trans_id_o == tid_q[dcache_rsp.data_rid])
    else flag_error("wrong trans_id");
  assert property (@(posedge clk_i) disable iff (!rst_ni) valid_o |-> result_o == exp_result)
    else flag_error("wrong load result");

  // ----------------------------------------
  // flush pulses and page offset stalls of a few cycles
  always @(posedge clk_i) begin : side_stimulus
    if (!side_on) begin
      flush_i               <= 1'b0;
      page_offset_matches_i <= 1'b0;
      match_left            <= 0;
    end else begin
      flush_i               <= ($urandom_range(0, 39) == 0);
      page_offset_matches_i <= (match_left != 0);
      if (match_left != 0) begin
        match_left <= match_left - 1;
      end else if ($urandom_range(0, 15) == 0) begin
        match_left <= $urandom_range(1, 6);
      end
    end
  end

  initial begin : stimulus
    void'($urandom(39));
    clk_i   = 1'b0;
    rst_ni  = 1'b1;
    valid_i = 1'b0;
    load_i  = '0;
    side_on = 1'b0;
    #1;
    rst_ni = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    side_on <= 1'b1;
    for (int n = 0; n < n_loads; n++) begin
      valid_i <= 1'b1;
      load_i  <= make_load(n);
      // request stays presented until popped
      do begin
        @(posedge clk_i);
      end while (!pop_ld_o);
      if ($urandom_range(0, 3) == 0) begin
        valid_i <= 1'b0;
        repeat ($urandom_range(1, 3)) @(posedge clk_i);
      end
    end
    valid_i <= 1'b0;
    side_on <= 1'b0;
    // drain
    do begin
      @(posedge clk_i);
    end while (outstanding != 0);
    repeat (4) @(posedge clk_i);
    assert (retired + flushed_rsp == pops)
      else flag_error("popped loads and responses do not add up");
    $display("loads=%0d retired=%0d flushed=%0d errors=%0d",
             pops, retired, flushed_rsp, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("run timed out after %0d ns with %0d loads in flight", watchdog_ns, outstanding);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- sim.f
design/load_pkg.sv
design/load_request_ctrl.sv
design/load_buffer.sv
design/load_result_align.sv
design/load_unit.sv
testbench/dcache_model.sv
testbench/tb_load_unit.sv

//--- run_sim.sh
#!/bin/sh
# build the load unit testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_load_unit -f sim.f -o tb_load_unit

./obj_dir/tb_load_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
  echo "simulation ok"
  exit 0
else
  echo "simulation reported errors, see sim.log"
  exit 1
fi
